// File: src/bus_pkg.sv
//********************
// Bus widths, address map and host/device indices for the compliance system
// Referenced by scoped name from the fabric, the devices and the top level
//********************
package bus_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  be_t;

  localparam int unsigned NrHosts   = 2;
  localparam int unsigned NrDevices = 2;

  // Hosts in decreasing priority
  typedef enum logic {
    TestUtilHost,
    ExtHost
  } bus_host_e;

  typedef enum logic {
    Ram,
    TestUtilDevice
  } bus_device_e;

  // 4 KB of RAM, depth must stay a power of two
  localparam int unsigned RamSizeWords = 1024;

  // Address windows
  localparam addr_t RamBase      = 32'h0000_0000;
  localparam addr_t RamMask      = ~addr_t'(RamSizeWords * 4 - 1);
  localparam addr_t TestUtilBase = 32'h0002_0000;
  localparam addr_t TestUtilMask = ~addr_t'(32'h3FF);  // 1 KB window

endpackage

// File: src/testutil_pkg.sv
//********************
// Test-utility register map and dump state encoding
//********************
package testutil_pkg;

  // Byte offset inside the 1 KB test-utility window
  typedef logic [9:0] offset_t;

  localparam offset_t SigBeginOffset = 10'h000;
  localparam offset_t SigEndOffset   = 10'h004;
  localparam offset_t HaltOffset     = 10'h008;

  // Signature dump sequencer
  typedef enum logic [1:0] {
    Idle,
    Request,
    WaitData,
    Done
  } dump_state_e;

endpackage

// File: src/bus_if.sv
//********************
// One req/gnt/rvalid bus link between a host and a device
// Hosts use the host modport, devices and fabric ports the device modport
//********************
`timescale 1ns/1ns

interface bus_if;

  // Request side
  logic           req;
  bus_pkg::addr_t addr;
  logic           we;
  bus_pkg::be_t   be;
  bus_pkg::data_t wdata;

  // Response side
  logic           gnt;
  logic           rvalid;
  bus_pkg::data_t rdata;
  logic           err;

  modport host (
    output req, addr, we, be, wdata,
    input  gnt, rvalid, rdata, err
  );

  modport device (
    input  req, addr, we, be, wdata,
    output gnt, rvalid, rdata, err
  );

endinterface

// File: src/bus_xbar.sv
//********************
// Fixed-priority crossbar from bus hosts to memory-mapped devices
// Unmapped addresses are granted and answered with an error response
//********************
`timescale 1ns/1ns

module bus_xbar (
  input  logic  clk_i,
  input  logic  reset_i,
  bus_if.device hosts   [bus_pkg::NrHosts],
  bus_if.host   devices [bus_pkg::NrDevices]
);

  // Host requests gathered into arrays
  logic           h_req   [bus_pkg::NrHosts];
  bus_pkg::addr_t h_addr  [bus_pkg::NrHosts];
  logic           h_we    [bus_pkg::NrHosts];
  bus_pkg::be_t   h_be    [bus_pkg::NrHosts];
  bus_pkg::data_t h_wdata [bus_pkg::NrHosts];

  // Device responses gathered into arrays
  logic           d_gnt    [bus_pkg::NrDevices];
  logic           d_rvalid [bus_pkg::NrDevices];
  bus_pkg::data_t d_rdata  [bus_pkg::NrDevices];
  logic           d_err    [bus_pkg::NrDevices];

  bus_pkg::addr_t dev_base [bus_pkg::NrDevices];
  bus_pkg::addr_t dev_mask [bus_pkg::NrDevices];

  logic                 any_req;
  bus_pkg::bus_host_e   sel_host;
  logic                 dev_hit;
  bus_pkg::bus_device_e sel_dev;
  logic                 granted;

  // Owner of the response due next cycle
  logic                 rsp_pending;
  bus_pkg::bus_host_e   rsp_host;
  bus_pkg::bus_device_e rsp_dev;
  logic                 rsp_unmapped;
  logic                 rsp_valid;
  logic                 rsp_err;

  assign dev_base[bus_pkg::Ram]            = bus_pkg::RamBase;
  assign dev_mask[bus_pkg::Ram]            = bus_pkg::RamMask;
  assign dev_base[bus_pkg::TestUtilDevice] = bus_pkg::TestUtilBase;
  assign dev_mask[bus_pkg::TestUtilDevice] = bus_pkg::TestUtilMask;

  // Lowest host index has the highest priority
  always_comb begin
    any_req  = 1'b0;
    sel_host = bus_pkg::TestUtilHost;
    for (int i = bus_pkg::NrHosts - 1; i >= 0; i--) begin
      if (h_req[i]) begin
        any_req  = 1'b1;
        sel_host = bus_pkg::bus_host_e'(i);
      end
    end
  end

  // Address decode of the winning host
  always_comb begin
    dev_hit = 1'b0;
    sel_dev = bus_pkg::Ram;
    for (int d = 0; d < bus_pkg::NrDevices; d++) begin
      if ((h_addr[sel_host] & dev_mask[d]) == dev_base[d]) begin
        dev_hit = 1'b1;
        sel_dev = bus_pkg::bus_device_e'(d);
      end
    end
  end

  // No device to wait on for a miss
  assign granted = any_req && (!dev_hit || d_gnt[sel_dev]);

  for (genvar d = 0; d < bus_pkg::NrDevices; d++) begin : g_dev
    assign devices[d].req   = any_req && dev_hit && (sel_dev == bus_pkg::bus_device_e'(d));
    assign devices[d].addr  = h_addr[sel_host];
    assign devices[d].we    = h_we[sel_host];
    assign devices[d].be    = h_be[sel_host];
    assign devices[d].wdata = h_wdata[sel_host];

    assign d_gnt[d]    = devices[d].gnt;
    assign d_rvalid[d] = devices[d].rvalid;
    assign d_rdata[d]  = devices[d].rdata;
    assign d_err[d]    = devices[d].err;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_pending  <= 1'b0;
      rsp_host     <= bus_pkg::TestUtilHost;
      rsp_dev      <= bus_pkg::Ram;
      rsp_unmapped <= 1'b0;
    end else begin
      rsp_pending <= granted;
      if (granted) begin
        rsp_host     <= sel_host;
        rsp_dev      <= sel_dev;
        rsp_unmapped <= !dev_hit;
      end
    end
  end

  assign rsp_valid = rsp_pending && (rsp_unmapped || d_rvalid[rsp_dev]);
  assign rsp_err   = rsp_unmapped || d_err[rsp_dev];

  for (genvar h = 0; h < bus_pkg::NrHosts; h++) begin : g_host
    assign h_req[h]   = hosts[h].req;
    assign h_addr[h]  = hosts[h].addr;
    assign h_we[h]    = hosts[h].we;
    assign h_be[h]    = hosts[h].be;
    assign h_wdata[h] = hosts[h].wdata;

    assign hosts[h].gnt    = granted && (sel_host == bus_pkg::bus_host_e'(h));
    assign hosts[h].rvalid = rsp_valid && (rsp_host == bus_pkg::bus_host_e'(h));
    assign hosts[h].err    = rsp_valid && rsp_err && (rsp_host == bus_pkg::bus_host_e'(h));
    // Zero data on any error
    assign hosts[h].rdata  = rsp_err ? '0 : d_rdata[rsp_dev];
  end

endmodule

// File: src/ram_1p.sv
//********************
// Single-port word RAM with byte enables behind a bus device link
//********************
`timescale 1ns/1ns

module ram_1p (
  input  logic  clk_i,
  input  logic  reset_i,
  bus_if.device bus
);

  bus_pkg::data_t                           mem [bus_pkg::RamSizeWords];
  logic [$clog2(bus_pkg::RamSizeWords)-1:0] word_idx;

  // Word index from the byte address
  assign word_idx = bus.addr[$clog2(bus_pkg::RamSizeWords)+1:2];

  // Always ready, never faults
  assign bus.gnt = 1'b1;
  assign bus.err = 1'b0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bus.rvalid <= 1'b0;
    end else begin
      bus.rvalid <= bus.req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      if (bus.we) begin
        for (int b = 0; b < $bits(bus_pkg::be_t); b++) begin
          if (bus.be[b]) begin
            mem[word_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
          end
        end
      end else begin
        bus.rdata <= mem[word_idx];
      end
    end
  end

endmodule

// File: src/riscv_testutil.sv
//********************
// Test utility with signature range registers and a halt register
// A halt write makes it read the signature range over its host link
//********************
`timescale 1ns/1ns

module riscv_testutil (
  input  logic           clk_i,
  input  logic           reset_i,
  bus_if.device          dev,
  bus_if.host            host,
  output logic           sig_valid_o,
  output bus_pkg::data_t sig_data_o,
  output logic           sig_done_o
);

  testutil_pkg::offset_t     reg_offset;
  logic                      reg_hit;
  logic                      halt_write;
  bus_pkg::addr_t            sig_begin_q;
  bus_pkg::addr_t            sig_end_q;
  bus_pkg::addr_t            dump_addr_q;
  logic                      in_range;
  testutil_pkg::dump_state_e state_q;

  assign reg_offset = dev.addr[$bits(testutil_pkg::offset_t)-1:0];
  assign reg_hit    = (reg_offset == testutil_pkg::SigBeginOffset) ||
                      (reg_offset == testutil_pkg::SigEndOffset) ||
                      (reg_offset == testutil_pkg::HaltOffset);
  assign halt_write = dev.req && dev.we && (reg_offset == testutil_pkg::HaltOffset);

  assign dev.gnt = 1'b1;

  // Signature range registers
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sig_begin_q <= '0;
      sig_end_q   <= '0;
    end else if (dev.req && dev.we) begin
      if (reg_offset == testutil_pkg::SigBeginOffset) begin
        sig_begin_q <= dev.wdata;
      end
      if (reg_offset == testutil_pkg::SigEndOffset) begin
        sig_end_q <= dev.wdata;
      end
    end
  end

  // Device response one cycle after the request
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dev.rvalid <= 1'b0;
      dev.err    <= 1'b0;
    end else begin
      dev.rvalid <= dev.req;
      dev.err    <= dev.req && !reg_hit;
    end
  end

  // Halt reads back as zero, so do errors
  always_ff @(posedge clk_i) begin
    dev.rdata <= '0;
    if (dev.req && !dev.we) begin
      if (reg_offset == testutil_pkg::SigBeginOffset) begin
        dev.rdata <= sig_begin_q;
      end
      if (reg_offset == testutil_pkg::SigEndOffset) begin
        dev.rdata <= sig_end_q;
      end
    end
  end

  // Range is half open, end excluded
  assign in_range = dump_addr_q < sig_end_q;

  // Dump reads only
  assign host.req   = (state_q == testutil_pkg::Request) && in_range;
  assign host.addr  = dump_addr_q;
  assign host.we    = 1'b0;
  assign host.be    = '1;
  assign host.wdata = '0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q     <= testutil_pkg::Idle;
      dump_addr_q <= '0;
      sig_valid_o <= 1'b0;
    end else begin
      sig_valid_o <= 1'b0;
      case (state_q)
        testutil_pkg::Idle: begin
          if (halt_write) begin
            state_q     <= testutil_pkg::Request;
            dump_addr_q <= sig_begin_q;
          end
        end
        testutil_pkg::Request: begin
          if (!in_range) begin
            state_q <= testutil_pkg::Done;
          end else if (host.gnt) begin
            state_q <= testutil_pkg::WaitData;
          end
        end
        testutil_pkg::WaitData: begin
          if (host.rvalid) begin
            sig_valid_o <= 1'b1;
            dump_addr_q <= dump_addr_q + bus_pkg::addr_t'(4);
            state_q     <= testutil_pkg::Request;
          end
        end
        default: begin
          // Done holds until reset
          state_q <= testutil_pkg::Done;
        end
      endcase
    end
  end

  // Signature word for the strobe
  always_ff @(posedge clk_i) begin
    if ((state_q == testutil_pkg::WaitData) && host.rvalid) begin
      sig_data_o <= host.rdata;
    end
  end

  assign sig_done_o = (state_q == testutil_pkg::Done);

endmodule

// File: src/compliance_sys.sv
//********************
// Compliance memory subsystem with RAM, test utility and crossbar
// The outside host drives the host_* ports in place of a core
//********************
`timescale 1ns/1ns

module compliance_sys (
  input  logic           clk_i,
  input  logic           reset_i,

  input  logic           host_req_i,
  input  logic           host_we_i,
  input  bus_pkg::addr_t host_addr_i,
  input  bus_pkg::be_t   host_be_i,
  input  bus_pkg::data_t host_wdata_i,
  output logic           host_gnt_o,
  output logic           host_rvalid_o,
  output logic           host_err_o,
  output bus_pkg::data_t host_rdata_o,

  output logic           sig_valid_o,
  output bus_pkg::data_t sig_data_o,
  output logic           sig_done_o
);

  bus_if host_bus [bus_pkg::NrHosts] ();
  bus_if dev_bus  [bus_pkg::NrDevices] ();

  // Outside host link
  assign host_bus[bus_pkg::ExtHost].req   = host_req_i;
  assign host_bus[bus_pkg::ExtHost].addr  = host_addr_i;
  assign host_bus[bus_pkg::ExtHost].we    = host_we_i;
  assign host_bus[bus_pkg::ExtHost].be    = host_be_i;
  assign host_bus[bus_pkg::ExtHost].wdata = host_wdata_i;

  assign host_gnt_o    = host_bus[bus_pkg::ExtHost].gnt;
  assign host_rvalid_o = host_bus[bus_pkg::ExtHost].rvalid;
  assign host_err_o    = host_bus[bus_pkg::ExtHost].err;
  assign host_rdata_o  = host_bus[bus_pkg::ExtHost].rdata;

  bus_xbar u_bus_xbar (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .hosts   (host_bus),
    .devices (dev_bus)
  );

  // Signature and program memory
  ram_1p u_ram (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .bus     (dev_bus[bus_pkg::Ram])
  );

  riscv_testutil u_riscv_testutil (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .dev         (dev_bus[bus_pkg::TestUtilDevice]),
    .host        (host_bus[bus_pkg::TestUtilHost]),
    .sig_valid_o (sig_valid_o),
    .sig_data_o  (sig_data_o),
    .sig_done_o  (sig_done_o)
  );

endmodule

// File: test/tb_clock.sv
//********************
// Testbench clock and reset, 8 ns period
// Reset is held 5 cycles at start and again after a restart request
//********************
`timescale 1ns/1ns

module tb_clock (
  input  logic restart_i,
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (5) @(posedge clk_o);
    reset_o <= 1'b0;
    forever begin
      @(posedge clk_o);
      if (restart_i) begin
        reset_o <= 1'b1;
        repeat (5) @(posedge clk_o);
        reset_o <= 1'b0;
      end
    end
  end

endmodule

// File: test/compliance_assert.sv
//********************
// Bus and signature protocol assertions, bound to the top level
//********************
`timescale 1ns/1ns

module compliance_assert (
  input logic clk_i,
  input logic reset_i,
  input logic host_gnt_o,
  input logic host_rvalid_o,
  input logic host_err_o,
  input logic sig_valid_o,
  input logic sig_done_o
);

  a_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (reset_i)
    host_gnt_o |=> host_rvalid_o)
    else $error("rvalid did not follow gnt by one cycle");

  a_no_rvalid_without_gnt: assert property (@(posedge clk_i) disable iff (reset_i)
    host_rvalid_o |-> $past(host_gnt_o))
    else $error("rvalid without a preceding gnt");

  a_no_sig_after_done: assert property (@(posedge clk_i) disable iff (reset_i)
    $past(sig_done_o) |-> !sig_valid_o)
    else $error("signature strobe after done");

  // First reset edge still shows the old state
  a_quiet_in_reset: assert property (@(posedge clk_i)
    (reset_i && $past(reset_i)) |->
      !(host_gnt_o || host_rvalid_o || host_err_o || sig_valid_o || sig_done_o))
    else $error("outputs active during reset");

endmodule

bind compliance_sys compliance_assert i_assert (.*);

// File: test/tb_checker.sv
//********************
// Scoreboard for the outside host and the signature stream
// Keeps a byte model of RAM built from granted writes
//********************
`timescale 1ns/1ns

module tb_checker (
  input logic           clk_i,
  input logic           reset_i,
  input logic           host_req_i,
  input logic           host_we_i,
  input bus_pkg::addr_t host_addr_i,
  input bus_pkg::be_t   host_be_i,
  input bus_pkg::data_t host_wdata_i,
  input logic           host_gnt_o,
  input logic           host_rvalid_o,
  input logic           host_err_o,
  input bus_pkg::data_t host_rdata_o,
  input logic           sig_valid_o,
  input bus_pkg::data_t sig_data_o
);

  logic [7:0]     model_mem [bus_pkg::RamSizeWords * 4];
  bus_pkg::addr_t q_addr [$];
  logic           q_we [$];
  bus_pkg::data_t q_data [$];
  logic           q_err [$];
  logic           q_model [$];
  bus_pkg::addr_t sig_q [$];
  int             test_count;
  int             error_count;
  int             dump_errors;

  initial begin
    for (int i = 0; i < bus_pkg::RamSizeWords * 4; i++) begin
      model_mem[i] = 8'h00;
    end
    test_count  = 0;
    error_count = 0;
    dump_errors = 0;
  end

  function automatic logic in_ram(input bus_pkg::addr_t a);
    return (a & bus_pkg::RamMask) == bus_pkg::RamBase;
  endfunction

  // Byte address within 4 KB
  function automatic bus_pkg::data_t model_word(input bus_pkg::addr_t a);
    logic [11:0] base;
    base = {a[11:2], 2'b00};
    return {model_mem[base + 3], model_mem[base + 2], model_mem[base + 1], model_mem[base]};
  endfunction

  task automatic expect_op(input bus_pkg::addr_t addr, input logic we,
                           input bus_pkg::data_t data, input logic err,
                           input logic use_model);
    q_addr.push_back(addr);
    q_we.push_back(we);
    q_data.push_back(data);
    q_err.push_back(err);
    q_model.push_back(use_model);
  endtask

  task automatic expect_dump(input bus_pkg::addr_t sig_begin, input bus_pkg::addr_t sig_end);
    bus_pkg::addr_t a;
    dump_errors = 0;
    for (a = sig_begin; a < sig_end; a = a + 4) begin
      sig_q.push_back(a);
    end
  endtask

  task automatic dump_finished(input bus_pkg::addr_t sig_begin, input bus_pkg::addr_t sig_end);
    if (sig_q.size() != 0) begin
      $display("ERROR at %0t ns: %0d signature words missing", $time, sig_q.size());
      dump_errors++;
      error_count++;
      sig_q.delete();
    end
    test_count++;
    $display("%s dump 0x%08h..0x%08h", (dump_errors == 0) ? "PASS" : "FAIL",
             sig_begin, sig_end);
  endtask

  task automatic check_response();
    bus_pkg::addr_t a;
    logic           we;
    bus_pkg::data_t exp;
    logic           exp_err;
    logic           use_model;
    int             errs;
    errs = 0;
    if (q_addr.size() == 0) begin
      $display("ERROR at %0t ns: rvalid with no outstanding request", $time);
      error_count++;
      return;
    end
    a         = q_addr.pop_front();
    we        = q_we.pop_front();
    exp       = q_data.pop_front();
    exp_err   = q_err.pop_front();
    use_model = q_model.pop_front();
    if (host_err_o !== exp_err) begin
      $display("ERROR at %0t ns: err %b at 0x%08h, expected %b", $time, host_err_o, a,
               exp_err);
      errs++;
    end
    if (!we) begin
      // Reads without a listed value take the model word
      if (use_model) begin
        exp = model_word(a);
      end
      if (host_rdata_o !== exp) begin
        $display("ERROR at %0t ns: read 0x%08h got 0x%08h, expected 0x%08h", $time, a,
                 host_rdata_o, exp);
        errs++;
      end else if (in_ram(a) && !exp_err && host_rdata_o !== model_word(a)) begin
        $display("ERROR at %0t ns: read 0x%08h got 0x%08h, RAM model holds 0x%08h", $time,
                 a, host_rdata_o, model_word(a));
        errs++;
      end
    end
    test_count++;
    error_count += errs;
    $display("%s %s 0x%08h", (errs == 0) ? "PASS" : "FAIL", we ? "write" : "read", a);
  endtask

  always @(posedge clk_i) begin
    if (!reset_i && host_req_i && host_gnt_o && host_we_i && in_ram(host_addr_i)) begin
      for (int b = 0; b < 4; b++) begin
        if (host_be_i[b]) begin
          model_mem[{host_addr_i[11:2], 2'(b)}] = host_wdata_i[8*b +: 8];
        end
      end
    end
    if (!reset_i && host_rvalid_o) begin
      check_response();
    end
    if (!reset_i && sig_valid_o) begin
      if (sig_q.size() == 0) begin
        $display("ERROR at %0t ns: unexpected signature word 0x%08h", $time, sig_data_o);
        dump_errors++;
        error_count++;
      end else if (sig_data_o !== model_word(sig_q[0])) begin
        $display("ERROR at %0t ns: signature 0x%08h got 0x%08h, expected 0x%08h", $time,
                 sig_q[0], sig_data_o, model_word(sig_q[0]));
        void'(sig_q.pop_front());
        dump_errors++;
        error_count++;
      end else begin
        void'(sig_q.pop_front());
      end
    end
  end

endmodule

// File: test/tb_compliance_sys.sv
//********************
// Testbench top for the compliance system
// Plays test/compliance_vectors.txt through the outside host ports
//********************
`timescale 1ns/1ns

module tb_compliance_sys;

  localparam int WaitLimit = 200;
  localparam int DumpLimit = 5000;

  logic           clk_i;
  logic           reset_i;
  logic           restart;
  logic           host_req_i;
  logic           host_we_i;
  bus_pkg::addr_t host_addr_i;
  bus_pkg::be_t   host_be_i;
  bus_pkg::data_t host_wdata_i;
  logic           host_gnt_o;
  logic           host_rvalid_o;
  logic           host_err_o;
  bus_pkg::data_t host_rdata_o;
  logic           sig_valid_o;
  bus_pkg::data_t sig_data_o;
  logic           sig_done_o;
  logic           timed_out;

  tb_clock i_clock (.restart_i(restart), .clk_o(clk_i), .reset_o(reset_i));

  compliance_sys i_dut (.*);

  tb_checker i_checker (.*);

  // Wait until a level is seen on a signal, bounded by a cycle limit
  task automatic wait_level(input int which, input logic level, input int limit,
                            output logic ok);
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < limit) begin
      @(posedge clk_i);
      case (which)
        0: seen = (host_gnt_o == level);
        1: seen = (host_rvalid_o == level);
        2: seen = (sig_done_o == level);
        default: seen = (reset_i == level);
      endcase
      cycles++;
    end
    ok = seen;
  endtask

  task automatic bus_access(input bus_pkg::addr_t addr, input logic we, input bus_pkg::be_t be,
                            input bus_pkg::data_t data, input logic err,
                            input logic use_model, output logic ok);
    i_checker.expect_op(addr, we, data, err, use_model);
    @(posedge clk_i);
    host_req_i   <= 1'b1;
    host_we_i    <= we;
    host_addr_i  <= addr;
    host_be_i    <= be;
    host_wdata_i <= data;
    wait_level(0, 1'b1, WaitLimit, ok);
    host_req_i <= 1'b0;
    if (!ok) begin
      $display("Timeout: access to 0x%08h was never granted", addr);
      return;
    end
    wait_level(1, 1'b1, WaitLimit, ok);
    if (!ok) begin
      $display("Timeout: no response for access to 0x%08h", addr);
    end
  endtask

  task automatic run_vectors(input int fd);
    string          line;
    logic [7:0]     op;
    logic [31:0]    f1;
    logic [31:0]    f2;
    logic [31:0]    f3;
    logic [31:0]    f4;
    logic           ok;
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 1 || line[0] == "#" || line[0] == "\n") begin
        continue;
      end
      void'($sscanf(line, "%c %h %h %h %h", op, f1, f2, f3, f4));
      ok = 1'b1;
      if (op == "W") begin
        bus_access(f1, 1'b1, f2[3:0], f3, f4[0], 1'b0, ok);
      end else if (op == "R") begin
        bus_access(f1, 1'b0, '0, f2, f3[0], 1'b0, ok);
      end else if (op == "D") begin
        i_checker.expect_dump(f1, f2);
        bus_access(bus_pkg::TestUtilBase + 32'h8, 1'b1, '1, '0, 1'b0, 1'b0, ok);
        // Outside read that competes with the dump
        if (ok) begin
          bus_access(f1, 1'b0, '0, '0, 1'b0, 1'b1, ok);
        end
        if (ok) begin
          wait_level(2, 1'b1, DumpLimit, ok);
          if (!ok) begin
            $display("Timeout: signature dump never finished");
          end
        end
        if (ok) begin
          i_checker.dump_finished(f1, f2);
        end
      end else if (op == "S") begin
        @(posedge clk_i);
        restart <= 1'b1;
        @(posedge clk_i);
        restart <= 1'b0;
        wait_level(3, 1'b1, WaitLimit, ok);
        if (ok) begin
          wait_level(3, 1'b0, WaitLimit, ok);
        end
        if (!ok) begin
          $display("Timeout: restart reset did not complete");
        end
      end
      if (!ok) begin
        timed_out = 1'b1;
        return;
      end
      repeat ($urandom % 4) @(posedge clk_i);
    end
  endtask

  initial begin
    int   fd;
    logic ok;
    restart      = 1'b0;
    host_req_i   = 1'b0;
    host_we_i    = 1'b0;
    host_addr_i  = '0;
    host_be_i    = '0;
    host_wdata_i = '0;
    timed_out    = 1'b0;
    void'($urandom(32'hd76b6613));
    fd = $fopen("test/compliance_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vectors file test/compliance_vectors.txt");
      timed_out = 1'b1;
    end else begin
      wait_level(3, 1'b0, WaitLimit, ok);
      if (!ok) begin
        $display("Timeout: reset never released");
        timed_out = 1'b1;
      end else begin
        run_vectors(fd);
      end
      $fclose(fd);
    end
    repeat (4) @(posedge clk_i);
    $display("Tests: %0d, errors: %0d", i_checker.test_count, i_checker.error_count);
    if (!timed_out && i_checker.error_count == 0 && i_checker.test_count > 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: compliance_sys.f
src/bus_pkg.sv
src/testutil_pkg.sv
src/bus_if.sv
src/bus_xbar.sv
src/ram_1p.sv
src/riscv_testutil.sv
src/compliance_sys.sv
test/tb_clock.sv
test/compliance_assert.sv
test/tb_checker.sv
test/tb_compliance_sys.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the compliance system testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f compliance_sys.f \
  --top-module tb_compliance_sys \
  -Mdir obj_dir -o sim_compliance_sys
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_compliance_sys > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
  exit 0
fi
exit 1

// File: test/compliance_vectors.txt
# W addr be data exp_err | R addr exp_data exp_err | D sig_begin sig_end | S restart
# All values hex
W 00000100 f 11223344 0
W 00000104 f a5a5a5a5 0
W 00000108 f 0badf00d 0
R 00000100 11223344 0
R 00000104 a5a5a5a5 0
W 00000104 5 00cc00ee 0
R 00000104 a5cca5ee 0
R 00000108 0badf00d 0
W 00030000 f deadbeef 1
R 00030000 00000000 1
R 0002000c 00000000 1
W 00020000 f 00000100 0
W 00020004 f 0000010c 0
R 00020000 00000100 0
R 00020004 0000010c 0
D 00000100 0000010c
S
W 00020000 f 00000104 0
W 00020004 f 00000104 0
D 00000104 00000104
